/* logic/sad_pkg.sv */
package sad_pkg;

    // reference depth, also the sliding window length
    localparam int REF_SAMPLES = 16;

    // one ADC sample and one reference sample
    localparam int SAMPLE_BITS = 8;

    // accumulator and threshold, top bit marks saturation
    localparam int SAD_WIDTH = 12;

    // window phase runs 0 .. REF_SAMPLES-1
    localparam int PHASE_WIDTH = 4;

    // byte index on the register port
    localparam int BYTECNT_WIDTH = 4;

    // trigger event counter in the status register
    localparam int TRIG_COUNT_WIDTH = 16;

    // register address map
    typedef enum logic [7:0] {
        REG_REFERENCE         = 8'h00,
        REG_THRESHOLD         = 8'h01,
        REG_STATUS            = 8'h02,
        REG_MULTIPLE_TRIGGERS = 8'h03,
        REG_ALWAYS_ARMED      = 8'h04,
        REG_REF_SAMPLES       = 8'h05
    } sad_reg_e;

endpackage

/* logic/sad_config_regs.sv */
`timescale 1ns/1ps

module sad_config_regs (
    input  logic                                          adc_sampleclk,
    input  logic                                          reset,
    input  sad_pkg::sad_reg_e                             reg_address,
    input  logic [sad_pkg::BYTECNT_WIDTH-1:0]             reg_bytecnt,
    input  logic [7:0]                                    reg_datai,
    input  logic                                          reg_read,
    input  logic                                          reg_write,
    input  logic                                          triggered,
    input  logic [sad_pkg::TRIG_COUNT_WIDTH-1:0]          trig_count,
    output logic [7:0]                                    reg_datao,
    output logic [sad_pkg::REF_SAMPLES*sad_pkg::SAMPLE_BITS-1:0] reference,
    output logic [sad_pkg::SAD_WIDTH-1:0]                 threshold,
    output logic                                          multiple_triggers,
    output logic                                          always_armed,
    output logic                                          status_clear
);

    import sad_pkg::*;

    logic [15:0] threshold_wide;
    logic [23:0] status_word;

    assign threshold_wide = 16'(threshold);
    // byte 0 bit 0 is the flag, bytes 1 and 2 the event count
    assign status_word = {trig_count, 7'b0, triggered};

    // byte writes from the host
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            reference         <= '0;
            threshold         <= '0;
            multiple_triggers <= 1'b0;
            always_armed      <= 1'b0;
            status_clear      <= 1'b0;
        end else begin
            status_clear <= reg_write && (reg_address == REG_STATUS);
            if (reg_write) begin
                case (reg_address)
                    REG_REFERENCE:
                        reference[reg_bytecnt*SAMPLE_BITS +: SAMPLE_BITS] <= reg_datai;
                    REG_THRESHOLD: begin
                        // low byte first
                        if (reg_bytecnt == 0)
                            threshold[7:0] <= reg_datai;
                        else if (reg_bytecnt == 1)
                            threshold[SAD_WIDTH-1:8] <= reg_datai[SAD_WIDTH-9:0];
                    end
                    REG_MULTIPLE_TRIGGERS: multiple_triggers <= reg_datai[0];
                    REG_ALWAYS_ARMED:      always_armed      <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    // read-back mux, zero unless a read is in progress
    always_comb begin
        reg_datao = 8'h00;
        if (reg_read) begin
            case (reg_address)
                REG_REFERENCE:
                    reg_datao = reference[reg_bytecnt*SAMPLE_BITS +: SAMPLE_BITS];
                REG_THRESHOLD:
                    reg_datao = (reg_bytecnt < 2) ? threshold_wide[reg_bytecnt*8 +: 8] : 8'h00;
                REG_STATUS:
                    reg_datao = (reg_bytecnt < 3) ? status_word[reg_bytecnt*8 +: 8] : 8'h00;
                REG_MULTIPLE_TRIGGERS: reg_datao = {7'b0, multiple_triggers};
                REG_ALWAYS_ARMED:      reg_datao = {7'b0, always_armed};
                REG_REF_SAMPLES:
                    reg_datao = (reg_bytecnt == 0) ? 8'(REF_SAMPLES) : 8'h00;
                default: reg_datao = 8'h00;
            endcase
        end
    end

    // host side never reads and writes together
    a_no_read_write: assert property (@(posedge adc_sampleclk) disable iff (reset)
        !(reg_read && reg_write));

endmodule

/* logic/sad_sample_gate.sv */
`timescale 1ns/1ps

module sad_sample_gate (
    input  logic                              adc_sampleclk,
    input  logic                              reset,
    input  logic                              armed,
    input  logic                              active,
    input  logic                              adc_error,
    input  logic                              always_armed,
    input  logic [sad_pkg::SAMPLE_BITS-1:0]   adc_data,
    output logic [sad_pkg::SAMPLE_BITS-1:0]   sample,
    output logic                              sample_valid,
    output logic [sad_pkg::PHASE_WIDTH-1:0]   phase,
    output logic                              window_full,
    output logic                              arm_start
);

    import sad_pkg::*;

    logic                   accept;
    logic                   armed_r;
    // consecutive accepted samples, saturates one short of a window
    logic [PHASE_WIDTH-1:0] fill;

    assign accept = (armed || always_armed) && active && !adc_error;

    always_ff @(posedge adc_sampleclk) begin
        if (accept)
            sample <= adc_data;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            sample_valid <= 1'b0;
            phase        <= '0;
            fill         <= '0;
            window_full  <= 1'b0;
            armed_r      <= 1'b0;
            arm_start    <= 1'b0;
        end else begin
            armed_r      <= armed;
            arm_start    <= armed && !armed_r;
            sample_valid <= accept;
            if (accept) begin
                // previous sample accepted means no gap, keep counting
                if (sample_valid && phase != PHASE_WIDTH'(REF_SAMPLES - 1))
                    phase <= phase + 1'b1;
                else
                    phase <= '0;
                if (fill != PHASE_WIDTH'(REF_SAMPLES - 1))
                    fill <= fill + 1'b1;
                window_full <= (fill == PHASE_WIDTH'(REF_SAMPLES - 1));
            end else begin
                fill        <= '0;
                window_full <= 1'b0;
            end
        end
    end

    // a full window needs back-to-back samples
    a_full_needs_run: assert property (@(posedge adc_sampleclk) disable iff (reset)
        window_full |-> sample_valid && $past(sample_valid));

endmodule

/* logic/sad_counter_bank.sv */
`timescale 1ns/1ps

module sad_counter_bank (
    input  logic                                          adc_sampleclk,
    input  logic                                          reset,
    input  logic [sad_pkg::SAMPLE_BITS-1:0]               sample,
    input  logic                                          sample_valid,
    input  logic [sad_pkg::PHASE_WIDTH-1:0]               phase,
    input  logic                                          window_full,
    input  logic [sad_pkg::REF_SAMPLES*sad_pkg::SAMPLE_BITS-1:0] reference,
    output logic [sad_pkg::SAD_WIDTH-1:0]                 sad_value,
    output logic                                          sad_valid
);

    import sad_pkg::*;

    // difference stage control
    logic                   diff_valid;
    logic                   diff_full;
    logic [PHASE_WIDTH-1:0] diff_phase;
    logic [PHASE_WIDTH-1:0] finish_idx;

    // each counter's sum including the current term
    logic [SAD_WIDTH-1:0]   total [REF_SAMPLES];

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            diff_valid <= 1'b0;
            diff_full  <= 1'b0;
            diff_phase <= '0;
        end else begin
            diff_valid <= sample_valid;
            diff_full  <= sample_valid && window_full;
            if (sample_valid)
                diff_phase <= phase;
        end
    end

    genvar c;
    generate
        for (c = 0; c < REF_SAMPLES; c++) begin : gen_counter
            logic [PHASE_WIDTH-1:0] ref_idx;
            logic [SAMPLE_BITS-1:0] ref_sample;
            logic [SAMPLE_BITS-1:0] diff;
            logic [SAD_WIDTH-1:0]   acc;

            // counter c sees reference sample (phase - c) mod REF_SAMPLES
            assign ref_idx    = phase - PHASE_WIDTH'(c);
            assign ref_sample = reference[ref_idx*SAMPLE_BITS +: SAMPLE_BITS];

            always_ff @(posedge adc_sampleclk) begin
                if (sample_valid) begin
                    if (sample > ref_sample)
                        diff <= sample - ref_sample;
                    else
                        diff <= ref_sample - sample;
                end
            end

            // restart at its own phase, hold once the saturation bit is set
            always_comb begin
                if (diff_phase == PHASE_WIDTH'(c))
                    total[c] = SAD_WIDTH'(diff);
                else if (acc[SAD_WIDTH-1])
                    total[c] = acc;
                else
                    total[c] = acc + SAD_WIDTH'(diff);
            end

            always_ff @(posedge adc_sampleclk) begin
                if (diff_valid)
                    acc <= total[c];
            end
        end
    endgenerate

    // counter whose last term lands on this phase
    assign finish_idx = diff_phase + 1'b1;

    always_ff @(posedge adc_sampleclk) begin
        if (diff_valid)
            sad_value <= total[finish_idx];
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            sad_valid <= 1'b0;
        else
            sad_valid <= diff_valid && diff_full;
    end

    // a new result stream starts two edges behind an accepted sample
    a_result_follows_sample: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(sad_valid) |-> $past(sample_valid, 2));

endmodule

/* logic/sad_trigger_control.sv */
`timescale 1ns/1ps

module sad_trigger_control (
    input  logic                                   adc_sampleclk,
    input  logic                                   reset,
    input  logic [sad_pkg::SAD_WIDTH-1:0]          sad_value,
    input  logic                                   sad_valid,
    input  logic [sad_pkg::SAD_WIDTH-1:0]          threshold,
    input  logic                                   multiple_triggers,
    input  logic                                   status_clear,
    input  logic                                   arm_start,
    output logic                                   trigger,
    output logic                                   triggered,
    output logic [sad_pkg::TRIG_COUNT_WIDTH-1:0]   trig_count
);

    logic trigger_r;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger    <= 1'b0;
            trigger_r  <= 1'b0;
            triggered  <= 1'b0;
            trig_count <= '0;
        end else begin
            trigger_r <= trigger;
            // lockout after the first event unless multiple triggers are allowed
            trigger <= sad_valid && (sad_value <= threshold)
                       && !(triggered && !multiple_triggers);

            if (status_clear || arm_start) begin
                triggered  <= 1'b0;
                trig_count <= '0;
            end else if (trigger && !trigger_r) begin
                triggered  <= 1'b1;
                trig_count <= trig_count + 1'b1;
            end
        end
    end

    // single-trigger mode only fires from an empty event count
    a_lockout: assert property (@(posedge adc_sampleclk) disable iff (reset)
        $rose(trigger) && !$past(multiple_triggers) |-> trig_count == '0);

endmodule

/* logic/sad_trigger_top.sv */
`timescale 1ns/1ps

module sad_trigger_top (
    input  logic                                adc_sampleclk,
    input  logic                                reset,
    input  logic                                armed,
    input  logic                                active,
    input  logic                                adc_error,
    input  logic [sad_pkg::SAMPLE_BITS-1:0]     adc_data,
    input  sad_pkg::sad_reg_e                   reg_address,
    input  logic [sad_pkg::BYTECNT_WIDTH-1:0]   reg_bytecnt,
    input  logic [7:0]                          reg_datai,
    input  logic                                reg_read,
    input  logic                                reg_write,
    output logic [7:0]                          reg_datao,
    output logic                                trigger
);

    import sad_pkg::*;

    // register file outputs
    logic [REF_SAMPLES*SAMPLE_BITS-1:0] reference;
    logic [SAD_WIDTH-1:0]               threshold;
    logic                               multiple_triggers;
    logic                               always_armed;
    logic                               status_clear;

    // status back from the trigger stage
    logic                               triggered;
    logic [TRIG_COUNT_WIDTH-1:0]        trig_count;

    // stage 1 to stage 2
    logic [SAMPLE_BITS-1:0]             sample;
    logic                               sample_valid;
    logic [PHASE_WIDTH-1:0]             phase;
    logic                               window_full;
    logic                               arm_start;

    // stage 2 to stage 3
    logic [SAD_WIDTH-1:0]               sad_value;
    logic                               sad_valid;

    sad_config_regs u_regs (
        .adc_sampleclk, .reset, .reg_address, .reg_bytecnt, .reg_datai,
        .reg_read, .reg_write, .triggered, .trig_count, .reg_datao,
        .reference, .threshold, .multiple_triggers, .always_armed, .status_clear
    );

    sad_sample_gate u_gate (
        .adc_sampleclk, .reset, .armed, .active, .adc_error, .always_armed,
        .adc_data, .sample, .sample_valid, .phase, .window_full, .arm_start
    );

    sad_counter_bank u_bank (
        .adc_sampleclk, .reset, .sample, .sample_valid, .phase, .window_full,
        .reference, .sad_value, .sad_valid
    );

    sad_trigger_control u_trig (
        .adc_sampleclk, .reset, .sad_value, .sad_valid, .threshold,
        .multiple_triggers, .status_clear, .arm_start, .trigger, .triggered, .trig_count
    );

endmodule

/* bench/sad_tests.svh */
    logic [SAMPLE_BITS-1:0] ref_bytes [REF_SAMPLES];
    logic [SAMPLE_BITS-1:0] stream_q [$];
    // drive time of the first streamed sample
    int                     stream_t0;

    task automatic new_reference();
        foreach (ref_bytes[j]) begin
            ref_bytes[j] = 8'($random(seed));
            reg_write_byte(REG_REFERENCE, j, ref_bytes[j]);
        end
    endtask

    task automatic add_noise(input int n);
        repeat (n) stream_q.push_back(8'($random(seed)));
    endtask

    // reference copy, each sample off by up to amp
    task automatic add_reference(input int amp);
        int v;
        foreach (ref_bytes[j]) begin
            v = int'(ref_bytes[j]);
            if (amp > 0)
                v += $random(seed) % (amp + 1);
            stream_q.push_back(8'((v < 0) ? 0 : (v > 255) ? 255 : v));
        end
    endtask

    // SAD of the window that ends at stream index last
    function automatic int window_sad(input int last);
        int sum;
        int d;
        sum = 0;
        for (int j = 0; j < REF_SAMPLES; j++) begin
            d = int'(stream_q[last - REF_SAMPLES + 1 + j]) - int'(ref_bytes[j]);
            sum += (d < 0) ? -d : d;
        end
        return sum;
    endfunction

    // drive edge, then capture, difference, accumulate and compare edges
    task automatic expect_triggers(input int thresh, input bit multi);
        bit prev;
        bit hit;
        prev = 1'b0;
        exp_times.delete();
        for (int i = REF_SAMPLES - 1; i < stream_q.size(); i++) begin
            hit = (window_sad(i) <= thresh);
            if (hit && !prev && (multi || exp_times.size() == 0))
                exp_times.push_back(stream_t0 + (i + 4) * CLK_PERIOD);
            prev = hit;
        end
    endtask

    // err_at is the sample sent with adc_error high, -1 for none
    task automatic stream_samples(input int err_at);
        trig_times.delete();
        foreach (stream_q[i]) begin
            @(posedge adc_sampleclk);
            if (i == 0)
                stream_t0 = int'($time);
            active    <= 1'b1;
            adc_error <= (i == err_at);
            adc_data  <= stream_q[i];
        end
        @(posedge adc_sampleclk);
        active    <= 1'b0;
        adc_error <= 1'b0;
        // pipeline drain
        repeat (8) @(posedge adc_sampleclk);
    endtask

    task automatic check_status(input logic [7:0] flag, input int count);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        reg_read_byte(REG_STATUS, 0, b0);
        reg_read_byte(REG_STATUS, 1, b1);
        reg_read_byte(REG_STATUS, 2, b2);
        check_byte("status flag", flag, b0);
        check_count("trigger count", TRIG_COUNT_WIDTH'(count), {b2, b1});
    endtask

    task automatic test_registers();
        logic [7:0] rd;
        start_test("registers");
        reg_write_byte(REG_THRESHOLD, 0, 8'h5a);
        reg_write_byte(REG_THRESHOLD, 1, 8'h03);
        reg_read_byte(REG_THRESHOLD, 0, rd);
        check_byte("threshold low", 8'h5a, rd);
        reg_read_byte(REG_THRESHOLD, 1, rd);
        check_byte("threshold high", 8'h03, rd);
        new_reference();
        foreach (ref_bytes[j]) begin
            reg_read_byte(REG_REFERENCE, j, rd);
            check_byte($sformatf("reference %0d", j), ref_bytes[j], rd);
        end
        reg_write_byte(REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        reg_write_byte(REG_ALWAYS_ARMED, 0, 8'h01);
        reg_read_byte(REG_MULTIPLE_TRIGGERS, 0, rd);
        check_byte("multiple triggers", 8'h01, rd);
        reg_read_byte(REG_ALWAYS_ARMED, 0, rd);
        check_byte("always armed", 8'h01, rd);
        reg_read_byte(REG_REF_SAMPLES, 0, rd);
        check_byte("ref samples", 8'd16, rd);
        reg_read_byte(sad_reg_e'(8'h3c), 0, rd);
        check_byte("unknown address", 8'h00, rd);
        reg_write_byte(REG_MULTIPLE_TRIGGERS, 0, 8'h00);
        reg_write_byte(REG_ALWAYS_ARMED, 0, 8'h00);
        end_test();
    endtask

    task automatic test_exact_match();
        start_test("exact match");
        reg_write_byte(REG_THRESHOLD, 0, 8'h00);
        reg_write_byte(REG_THRESHOLD, 1, 8'h00);
        reg_write_byte(REG_STATUS, 0, 8'h00);
        stream_q.delete();
        add_noise(21);
        add_reference(0);
        add_noise(9);
        stream_samples(-1);
        exp_times.delete();
        exp_times.push_back(stream_t0 + (21 + REF_SAMPLES - 1 + 4) * CLK_PERIOD);
        check_trigger_times();
        check_status(8'h01, 1);
        end_test();
    endtask

    task automatic test_threshold();
        start_test("threshold");
        reg_write_byte(REG_THRESHOLD, 0, 8'd27);
        reg_write_byte(REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        stream_q.delete();
        repeat (6) begin
            add_noise(12);
            add_reference(3);
        end
        add_noise(4);
        stream_samples(-1);
        expect_triggers(27, 1'b1);
        check_trigger_times();
        end_test();
    endtask

    task automatic test_lockout();
        start_test("lockout");
        reg_write_byte(REG_THRESHOLD, 0, 8'h00);
        reg_write_byte(REG_MULTIPLE_TRIGGERS, 0, 8'h00);
        reg_write_byte(REG_STATUS, 0, 8'h00);
        stream_q.delete();
        add_noise(20);
        add_reference(0);
        add_noise(20);
        add_reference(0);
        add_noise(6);
        stream_samples(-1);
        expect_triggers(0, 1'b0);
        check_trigger_times();
        check_status(8'h01, 1);
        reg_write_byte(REG_STATUS, 0, 8'h00);
        check_status(8'h00, 0);
        reg_write_byte(REG_MULTIPLE_TRIGGERS, 0, 8'h01);
        stream_samples(-1);
        expect_triggers(0, 1'b1);
        check_trigger_times();
        check_status(8'h01, 2);
        end_test();
    endtask

    task automatic test_gating();
        start_test("gating");
        reg_write_byte(REG_STATUS, 0, 8'h00);
        stream_q.delete();
        add_noise(10);
        add_reference(0);
        add_noise(6);
        @(posedge adc_sampleclk);
        armed <= 1'b0;
        stream_samples(-1);
        exp_times.delete();
        check_trigger_times();
        reg_write_byte(REG_ALWAYS_ARMED, 0, 8'h01);
        stream_samples(-1);
        expect_triggers(0, 1'b1);
        check_trigger_times();
        // error halfway through the reference copy
        stream_samples(10 + REF_SAMPLES / 2);
        exp_times.delete();
        check_trigger_times();
        check_status(8'h01, 1);
        @(posedge adc_sampleclk);
        armed <= 1'b1;
        repeat (3) @(posedge adc_sampleclk);
        check_status(8'h00, 0);
        end_test();
    endtask

/* bench/sad_tb.sv */
`timescale 1ns/1ps

module sad_tb;

    import sad_pkg::*;

    localparam int CLK_PERIOD = 8;
    // cycle budget for registers, exact match, threshold, lockout and gating
    localparam int TEST_CYCLES = 150 + 150 + 250 + 350 + 350;

    logic                     adc_sampleclk = 1'b0;
    logic                     reset;
    logic                     armed;
    logic                     active;
    logic                     adc_error;
    logic [SAMPLE_BITS-1:0]   adc_data;
    sad_reg_e                 reg_address;
    logic [BYTECNT_WIDTH-1:0] reg_bytecnt;
    logic [7:0]               reg_datai;
    logic                     reg_read;
    logic                     reg_write;
    logic [7:0]               reg_datao;
    logic                     trigger;

    int    seed = 32'h4c75;
    int    errors = 0;
    int    checks = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_errors = 0;
    string test_name;
    logic  trigger_prev = 1'b0;
    // rise times observed and predicted, in ns of the setting clock edge
    int    trig_times [$];
    int    exp_times [$];

    always #(CLK_PERIOD/2) adc_sampleclk = ~adc_sampleclk;

    sad_trigger_top dut (.*);

    // stamp each trigger rise with the edge that set it
    always @(negedge adc_sampleclk) begin
        if (trigger && !trigger_prev)
            trig_times.push_back(int'($time) - CLK_PERIOD/2);
        trigger_prev = trigger;
    end

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s: %s expected 0x%02h, actual 0x%02h",
                     test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input logic [TRIG_COUNT_WIDTH-1:0] exp,
                               input logic [TRIG_COUNT_WIDTH-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s: %s expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_trigger_times();
        checks++;
        if (trig_times.size() != exp_times.size()) begin
            errors++;
            $display("** Error: %s: trigger events expected %0d, actual %0d",
                     test_name, exp_times.size(), trig_times.size());
        end else begin
            foreach (exp_times[i]) begin
                if (trig_times[i] != exp_times[i]) begin
                    errors++;
                    $display("** Error: %s: trigger %0d expected at %0d ns, actual %0d ns",
                             test_name, i, exp_times[i], trig_times[i]);
                end
            end
        end
    endtask

    task automatic reg_write_byte(input sad_reg_e addr, input int idx, input logic [7:0] data);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= BYTECNT_WIDTH'(idx);
        reg_datai   <= data;
        reg_write   <= 1'b1;
        @(posedge adc_sampleclk);
        reg_write <= 1'b0;
    endtask

    // read data is combinational, sampled mid-cycle
    task automatic reg_read_byte(input sad_reg_e addr, input int idx, output logic [7:0] data);
        @(posedge adc_sampleclk);
        reg_address <= addr;
        reg_bytecnt <= BYTECNT_WIDTH'(idx);
        reg_read    <= 1'b1;
        @(negedge adc_sampleclk);
        data = reg_datao;
        @(posedge adc_sampleclk);
        reg_read <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - test_errors);
        end
    endtask

    `include "sad_tests.svh"

    initial begin
        reset       = 1'b1;
        armed       = 1'b0;
        active      = 1'b0;
        adc_error   = 1'b0;
        adc_data    = '0;
        reg_address = REG_REFERENCE;
        reg_bytecnt = '0;
        reg_datai   = '0;
        reg_read    = 1'b0;
        reg_write   = 1'b0;
        repeat (3) @(posedge adc_sampleclk);
        reset <= 1'b0;
        armed <= 1'b1;
        test_registers();
        test_exact_match();
        test_threshold();
        test_lockout();
        test_gating();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish", TEST_CYCLES * 2);
        $display("sim failed");
        $finish;
    end

endmodule

/* project.f */
+incdir+bench
logic/sad_pkg.sv
logic/sad_config_regs.sv
logic/sad_sample_gate.sv
logic/sad_counter_bank.sv
logic/sad_trigger_control.sv
logic/sad_trigger_top.sv
bench/sad_tb.sv
